/* all.f */
source/rv32i_types.sv
source/ex_mem_register.sv
source/mem_stage.sv
source/data_memory.sv
source/write_back_stage.sv
source/mem_wb_top.sv
sim/mem_wb_properties.sv
sim/mem_wb_tb.sv

/* sim/mem_wb_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_properties
import rv32i_types::*;
(
    input logic       clk,
    input logic       reset,
    input logic [3:0] dmem_rmask,
    input logic [3:0] dmem_wmask,
    input commit_t    commit
);

    // one item either reads or writes the data memory, never both.
    mask_exclusive: assert property (@(posedge clk) disable iff (reset)
        !((|dmem_rmask) && (|dmem_wmask)))
        else $error("read and write masks are active in the same cycle");

    regf_we_legal: assert property (@(posedge clk) disable iff (reset)
        commit.regf_we |-> (commit.valid && (commit.rd_s != 5'd0)))
        else $error("register write without a valid commit or with rd zero");

    // the writeback register is cleared by the first reset edge.
    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !commit.valid)
        else $error("commit valid while reset is high");

endmodule

`default_nettype wire

/* sim/mem_wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_tb
import rv32i_types::*;
();

    localparam int DMEM_WORDS = 256;
    localparam int NUM_ROWS   = 36;
    localparam int NUM_FILL   = 6;

    typedef struct packed {
        mem_op_t     op;
        wb_sel_t     sel;
        logic [31:0] addr;
        logic [31:0] rs2;
        logic [31:0] uimm;
        logic        br;
        logic [4:0]  rd;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    exe_result_t exe_result;
    commit_t     commit;

    logic [31:0] ref_mem [DMEM_WORDS] = '{default: 32'h0};
    commit_t     exp_q [$];
    int          due_q [$];
    int          cycle_count = 0;

    // op, sel, address, rs2, u_imm, br_en, rd.
    row_t table_rows [NUM_ROWS] = '{
        '{mem_sw,   wb_none, 32'h0000_0100, 32'h1122_3344, 32'h0, 1'b0, 5'd0},
        '{mem_sb,   wb_none, 32'h0000_0100, 32'h0000_00aa, 32'h0, 1'b0, 5'd0},
        '{mem_sb,   wb_none, 32'h0000_0101, 32'h0000_00bb, 32'h0, 1'b0, 5'd0},
        '{mem_sb,   wb_none, 32'h0000_0102, 32'h0000_00cc, 32'h0, 1'b0, 5'd0},
        '{mem_sb,   wb_none, 32'h0000_0103, 32'hffff_ffdd, 32'h0, 1'b0, 5'd0},
        '{mem_lw,   wb_mem,  32'h0000_0100, 32'h0,         32'h0, 1'b0, 5'd5},
        '{mem_sh,   wb_none, 32'h0000_0104, 32'h0000_1234, 32'h0, 1'b0, 5'd0},
        '{mem_sh,   wb_none, 32'h0000_0106, 32'h5678_abcd, 32'h0, 1'b0, 5'd0},
        '{mem_lw,   wb_mem,  32'h0000_0104, 32'h0,         32'h0, 1'b0, 5'd6},
        '{mem_sw,   wb_none, 32'h0000_0108, 32'h80f1_7ffe, 32'h0, 1'b0, 5'd0},
        '{mem_lb,   wb_mem,  32'h0000_0108, 32'h0,         32'h0, 1'b0, 5'd7},
        '{mem_lb,   wb_mem,  32'h0000_0109, 32'h0,         32'h0, 1'b0, 5'd7},
        '{mem_lb,   wb_mem,  32'h0000_010a, 32'h0,         32'h0, 1'b0, 5'd7},
        '{mem_lb,   wb_mem,  32'h0000_010b, 32'h0,         32'h0, 1'b0, 5'd7},
        '{mem_lbu,  wb_mem,  32'h0000_0108, 32'h0,         32'h0, 1'b0, 5'd8},
        '{mem_lbu,  wb_mem,  32'h0000_0109, 32'h0,         32'h0, 1'b0, 5'd8},
        '{mem_lbu,  wb_mem,  32'h0000_010a, 32'h0,         32'h0, 1'b0, 5'd8},
        '{mem_lbu,  wb_mem,  32'h0000_010b, 32'h0,         32'h0, 1'b0, 5'd8},
        '{mem_lh,   wb_mem,  32'h0000_0108, 32'h0,         32'h0, 1'b0, 5'd9},
        '{mem_lh,   wb_mem,  32'h0000_010a, 32'h0,         32'h0, 1'b0, 5'd9},
        '{mem_lhu,  wb_mem,  32'h0000_0108, 32'h0,         32'h0, 1'b0, 5'd10},
        '{mem_lhu,  wb_mem,  32'h0000_010a, 32'h0,         32'h0, 1'b0, 5'd10},
        '{mem_none, wb_alu,  32'hdead_beef, 32'h0, 32'h0,         1'b0, 5'd1},
        '{mem_none, wb_uimm, 32'h0,         32'h0, 32'h1234_5000, 1'b0, 5'd2},
        '{mem_none, wb_br,   32'h0,         32'h0, 32'h0,         1'b1, 5'd3},
        '{mem_none, wb_br,   32'h0,         32'h0, 32'h0,         1'b0, 5'd3},
        '{mem_none, wb_alu,  32'h0bad_f00d, 32'h0, 32'h0,         1'b0, 5'd0},
        '{mem_none, wb_none, 32'h0000_0042, 32'h0, 32'h0,         1'b1, 5'd4},
        '{mem_lh,   wb_mem,  32'h0000_0109, 32'h0,         32'h0, 1'b0, 5'd9},
        '{mem_lw,   wb_mem,  32'h0000_010a, 32'h0,         32'h0, 1'b0, 5'd9},
        '{mem_sh,   wb_none, 32'h0000_0101, 32'hffff_ffff, 32'h0, 1'b0, 5'd0},
        '{mem_sw,   wb_none, 32'h0000_0102, 32'hffff_ffff, 32'h0, 1'b0, 5'd0},
        '{mem_lw,   wb_mem,  32'h0000_0100, 32'h0,         32'h0, 1'b0, 5'd11},
        '{mem_sw,   wb_none, 32'h0000_010c, 32'hcafe_f00d, 32'h0, 1'b0, 5'd0},
        '{mem_sb,   wb_none, 32'h0000_010d, 32'h0000_0055, 32'h0, 1'b0, 5'd0},
        '{mem_lhu,  wb_mem,  32'h0000_010c, 32'h0,         32'h0, 1'b0, 5'd12}
    };

    mem_wb_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .exe_result (exe_result),
        .commit     (commit)
    );

    bind mem_wb_top mem_wb_properties props_i (
        .clk        (clk),
        .reset      (reset),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .commit     (commit)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    function automatic logic [31:0] load_value(input mem_op_t op, input logic [31:0] word,
                                               input logic [1:0] off);
        logic [31:0] lane;
        lane = word >> (8 * off); // the addressed byte moves down to bit 0.
        case (op)
            mem_lb:  return {{24{lane[7]}}, lane[7:0]};
            mem_lbu: return {24'd0, lane[7:0]};
            mem_lh:  return {{16{lane[15]}}, lane[15:0]};
            mem_lhu: return {16'd0, lane[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic issue_row(input row_t row, input int index);
        exe_result_t item;
        commit_t     exp;
        logic [1:0]  off;
        int          idx;
        logic        is_half;
        logic        is_word;
        logic        mis;
        item        = '0;
        item.valid  = 1'b1;
        item.pc     = $urandom;
        item.order  = 64'(index);
        item.inst   = $urandom;
        item.mem_op = row.op;
        item.wb_sel = row.sel;
        item.alu_out = row.addr;
        item.br_en  = row.br;
        item.u_imm  = row.uimm;
        item.rs2_v  = row.rs2;
        item.rd_s   = row.rd;
        exe_result  = item;

        off     = row.addr[1:0];
        idx     = int'((row.addr >> 2) % DMEM_WORDS);
        is_half = row.op inside {mem_lh, mem_lhu, mem_sh};
        is_word = row.op inside {mem_lw, mem_sw};
        mis     = (is_half && off[0]) || (is_word && (off != 2'b00));
        if (!mis) begin
            case (row.op)
                mem_sb:  ref_mem[idx][8*off +: 8] = row.rs2[7:0];
                mem_sh:  ref_mem[idx][8*off +: 16] = row.rs2[15:0];
                mem_sw:  ref_mem[idx] = row.rs2;
                default: ;
            endcase
        end

        exp            = '0;
        exp.valid      = 1'b1;
        exp.order      = item.order;
        exp.pc         = item.pc;
        exp.rd_s       = row.rd;
        exp.misaligned = mis;
        exp.regf_we    = (row.sel != wb_none) && (row.rd != 5'd0) && !mis;
        case (row.sel)
            wb_alu:  exp.rd_v = row.addr;
            wb_uimm: exp.rd_v = row.uimm;
            wb_br:   exp.rd_v = {31'd0, row.br};
            wb_mem:  exp.rd_v = load_value(row.op, ref_mem[idx], off);
            default: exp.rd_v = 32'd0;
        endcase
        exp_q.push_back(exp);
        due_q.push_back(cycle_count + 2); // sampled at the next edge and shown after the one after.
    endtask

    // commit is sampled mid-cycle, away from the edge that updates it.
    always @(negedge clk) begin
        commit_t exp;
        int      due;
        if (!reset && commit.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A commit arrived with no instruction outstanding");
                $display("Simulation failed");
                $fatal(1, "unexpected commit");
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                check_value("commit cycle", 64'(cycle_count), 64'(due));
                check_value("commit.order", commit.order, exp.order);
                check_value("commit.pc", 64'(commit.pc), 64'(exp.pc));
                check_value("commit.rd_s", 64'(commit.rd_s), 64'(exp.rd_s));
                check_value("commit.misaligned", 64'(commit.misaligned), 64'(exp.misaligned));
                check_value("commit.regf_we", 64'(commit.regf_we), 64'(exp.regf_we));
                if (!exp.misaligned) begin // a misaligned load reads nothing, so rd_v is open.
                    check_value("commit.rd_v", 64'(commit.rd_v), 64'(exp.rd_v));
                end
            end
        end
    end

    initial begin
        row_t fill;
        int   waited;
        void'($urandom(32'h75409c01));
        exe_result = '0;
        reset      = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            issue_row(table_rows[i], i);
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < NUM_FILL; i++) begin
            fill      = '0;
            fill.op   = mem_none;
            fill.sel  = wb_sel_t'(3'd1 + 3'($urandom % 3)); // alu, upper immediate or branch.
            fill.addr = $urandom;
            fill.uimm = $urandom;
            fill.br   = 1'($urandom);
            fill.rd   = 5'($urandom);
            issue_row(fill, NUM_ROWS + i);
            @(posedge clk);
            #1;
        end
        exe_result = '0;

        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: commits stopped arriving, %0d still outstanding", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "timeout");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic [31:0] dmem_addr,
    input  logic [3:0]  dmem_rmask,
    input  logic [3:0]  dmem_wmask,
    input  logic [31:0] dmem_wdata,
    output logic [31:0] dmem_rdata
);

    localparam int INDEX_W = $clog2(DMEM_WORDS);

    logic [31:0]        mem [DMEM_WORDS] = '{default: 32'h0000_0000};
    logic [INDEX_W-1:0] index;

    assign index = dmem_addr[2 +: INDEX_W]; // addresses wrap modulo the depth.

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_wmask[b]) begin
                mem[index][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    // the read sees the word as it stood before this edge's write.
    always_ff @(posedge clk) begin
        if (|dmem_rmask) begin
            dmem_rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* source/ex_mem_register.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_register
import rv32i_types::*;
(
    input  logic              clk,
    input  logic              reset,
    input  exe_result_t       exe_result,
    output ex_mem_stage_reg_t ex_mem_stage_reg
);

    logic [1:0]  byte_off;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] wdata;

    assign byte_off = exe_result.alu_out[1:0];

    always_comb begin
        rmask = 4'b0000;
        wmask = 4'b0000;
        wdata = exe_result.rs2_v;
        case (exe_result.mem_op)
            mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu: begin
                rmask = 4'b1111; // the whole word is read and writeback picks the lane.
            end
            mem_sb: begin
                wmask = 4'b0001 << byte_off;
                wdata = {4{exe_result.rs2_v[7:0]}};
            end
            mem_sh: begin
                wmask = 4'b0011 << byte_off; // odd offsets are caught by the memory stage.
                wdata = {2{exe_result.rs2_v[15:0]}};
            end
            mem_sw: begin
                wmask = 4'b1111;
            end
            default: begin
                rmask = 4'b0000;
                wmask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem_stage_reg.valid <= 1'b0;
        end else begin
            ex_mem_stage_reg.valid <= exe_result.valid;
        end
        ex_mem_stage_reg.pc        <= exe_result.pc;
        ex_mem_stage_reg.order     <= exe_result.order;
        ex_mem_stage_reg.inst      <= exe_result.inst;
        ex_mem_stage_reg.mem_op    <= exe_result.mem_op;
        ex_mem_stage_reg.wb_sel    <= exe_result.wb_sel;
        ex_mem_stage_reg.alu_out   <= exe_result.alu_out;
        ex_mem_stage_reg.br_en     <= exe_result.br_en;
        ex_mem_stage_reg.u_imm     <= exe_result.u_imm;
        ex_mem_stage_reg.rd_s      <= exe_result.rd_s;
        ex_mem_stage_reg.mem_addr  <= {exe_result.alu_out[31:2], 2'b00};
        ex_mem_stage_reg.mem_rmask <= rmask;
        ex_mem_stage_reg.mem_wmask <= wmask;
        ex_mem_stage_reg.mem_wdata <= wdata;
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
import rv32i_types::*;
(
    input  ex_mem_stage_reg_t ex_mem_stage_reg,
    output logic [31:0]       dmem_addr,
    output logic [3:0]        dmem_rmask,
    output logic [3:0]        dmem_wmask,
    output logic [31:0]       dmem_wdata,
    output mem_wb_stage_reg_t mem_wb_stage_reg
);

    mem_op_t    mem_op;
    logic [1:0] byte_off;
    logic       is_half;
    logic       is_word;
    logic       misaligned;
    logic       access_ok;
    logic [3:0] rmask;
    logic [3:0] wmask;

    assign mem_op   = ex_mem_stage_reg.mem_op;
    assign byte_off = ex_mem_stage_reg.alu_out[1:0];
    assign is_half  = (mem_op == mem_lh) || (mem_op == mem_lhu) || (mem_op == mem_sh);
    assign is_word  = (mem_op == mem_lw) || (mem_op == mem_sw);

    assign misaligned = (is_half && byte_off[0]) || (is_word && (byte_off != 2'b00));
    assign access_ok  = ex_mem_stage_reg.valid && !misaligned;

    assign rmask = access_ok ? ex_mem_stage_reg.mem_rmask : 4'b0000;
    assign wmask = access_ok ? ex_mem_stage_reg.mem_wmask : 4'b0000;

    assign dmem_addr  = ex_mem_stage_reg.mem_addr;
    assign dmem_rmask = rmask;
    assign dmem_wmask = wmask;
    assign dmem_wdata = ex_mem_stage_reg.mem_wdata;

    always_comb begin
        mem_wb_stage_reg.valid      = ex_mem_stage_reg.valid;
        mem_wb_stage_reg.pc         = ex_mem_stage_reg.pc;
        mem_wb_stage_reg.order      = ex_mem_stage_reg.order;
        mem_wb_stage_reg.inst       = ex_mem_stage_reg.inst;
        mem_wb_stage_reg.mem_op     = ex_mem_stage_reg.mem_op;
        mem_wb_stage_reg.wb_sel     = ex_mem_stage_reg.wb_sel;
        mem_wb_stage_reg.alu_out    = ex_mem_stage_reg.alu_out;
        mem_wb_stage_reg.br_en      = ex_mem_stage_reg.br_en;
        mem_wb_stage_reg.u_imm      = ex_mem_stage_reg.u_imm;
        mem_wb_stage_reg.rd_s       = ex_mem_stage_reg.rd_s;
        mem_wb_stage_reg.mem_addr   = ex_mem_stage_reg.mem_addr;
        mem_wb_stage_reg.mem_rmask  = rmask;
        mem_wb_stage_reg.mem_wmask  = wmask;
        mem_wb_stage_reg.misaligned = misaligned;
    end

endmodule

`default_nettype wire

/* source/mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top
import rv32i_types::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  exe_result_t exe_result,
    output commit_t     commit
);

    ex_mem_stage_reg_t ex_mem_stage_reg;
    mem_wb_stage_reg_t mem_wb_stage_reg;
    logic [31:0]       dmem_addr;
    logic [3:0]        dmem_rmask;
    logic [3:0]        dmem_wmask;
    logic [31:0]       dmem_wdata;
    logic [31:0]       dmem_rdata;

    ex_mem_register ex_mem_register_i (
        .clk              (clk),
        .reset            (reset),
        .exe_result       (exe_result),
        .ex_mem_stage_reg (ex_mem_stage_reg)
    );

    mem_stage mem_stage_i (
        .ex_mem_stage_reg (ex_mem_stage_reg),
        .dmem_addr        (dmem_addr),
        .dmem_rmask       (dmem_rmask),
        .dmem_wmask       (dmem_wmask),
        .dmem_wdata       (dmem_wdata),
        .mem_wb_stage_reg (mem_wb_stage_reg)
    );

    data_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) data_memory_i (
        .clk        (clk),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    write_back_stage write_back_stage_i (
        .clk              (clk),
        .reset            (reset),
        .mem_wb_stage_reg (mem_wb_stage_reg),
        .dmem_rdata       (dmem_rdata),
        .commit           (commit)
    );

endmodule

`default_nettype wire

/* source/rv32i_types.sv */
`default_nettype none

package rv32i_types;

    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_t;

    typedef enum logic [2:0] {
        wb_none = 3'd0,
        wb_alu  = 3'd1,
        wb_uimm = 3'd2,
        wb_br   = 3'd3,
        wb_mem  = 3'd4
    } wb_sel_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
        logic [31:0] inst;
        mem_op_t     mem_op;
        wb_sel_t     wb_sel;
        logic [31:0] alu_out; // also the byte address of a load or store.
        logic        br_en;
        logic [31:0] u_imm;
        logic [31:0] rs2_v;
        logic [4:0]  rd_s;
    } exe_result_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
        logic [31:0] inst;
        mem_op_t     mem_op;
        wb_sel_t     wb_sel;
        logic [31:0] alu_out;
        logic        br_en;
        logic [31:0] u_imm;
        logic [4:0]  rd_s;
        logic [31:0] mem_addr; // word aligned.
        logic [3:0]  mem_rmask;
        logic [3:0]  mem_wmask;
        logic [31:0] mem_wdata;
    } ex_mem_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
        logic [31:0] inst;
        mem_op_t     mem_op;
        wb_sel_t     wb_sel;
        logic [31:0] alu_out;
        logic        br_en;
        logic [31:0] u_imm;
        logic [4:0]  rd_s;
        logic [31:0] mem_addr;
        logic [3:0]  mem_rmask; // zero when the access did not go to memory.
        logic [3:0]  mem_wmask;
        logic        misaligned;
    } mem_wb_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] order;
        logic [31:0] pc;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
        logic        regf_we;
        logic        misaligned;
    } commit_t;

endpackage

`default_nettype wire

/* source/write_back_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back_stage
import rv32i_types::*;
(
    input  logic              clk,
    input  logic              reset,
    input  mem_wb_stage_reg_t mem_wb_stage_reg,
    input  logic [31:0]       dmem_rdata,
    output commit_t           commit
);

    mem_wb_stage_reg_t wb_reg;
    logic [1:0]        byte_off;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    logic [31:0]       load_v;
    logic [31:0]       rd_v;
    logic              regf_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg.valid <= 1'b0;
        end else begin
            wb_reg.valid <= mem_wb_stage_reg.valid;
        end
        wb_reg.pc         <= mem_wb_stage_reg.pc;
        wb_reg.order      <= mem_wb_stage_reg.order;
        wb_reg.inst       <= mem_wb_stage_reg.inst;
        wb_reg.mem_op     <= mem_wb_stage_reg.mem_op;
        wb_reg.wb_sel     <= mem_wb_stage_reg.wb_sel;
        wb_reg.alu_out    <= mem_wb_stage_reg.alu_out;
        wb_reg.br_en      <= mem_wb_stage_reg.br_en;
        wb_reg.u_imm      <= mem_wb_stage_reg.u_imm;
        wb_reg.rd_s       <= mem_wb_stage_reg.rd_s;
        wb_reg.mem_addr   <= mem_wb_stage_reg.mem_addr;
        wb_reg.mem_rmask  <= mem_wb_stage_reg.mem_rmask;
        wb_reg.mem_wmask  <= mem_wb_stage_reg.mem_wmask;
        wb_reg.misaligned <= mem_wb_stage_reg.misaligned;
    end

    assign byte_off  = wb_reg.alu_out[1:0];
    assign load_byte = dmem_rdata[8*byte_off +: 8];
    assign load_half = dmem_rdata[16*byte_off[1] +: 16]; // lane 0 or lane 2 only.

    always_comb begin
        case (wb_reg.mem_op)
            mem_lb:  load_v = {{24{load_byte[7]}}, load_byte};
            mem_lbu: load_v = {24'h00_0000, load_byte};
            mem_lh:  load_v = {{16{load_half[15]}}, load_half};
            mem_lhu: load_v = {16'h0000, load_half};
            mem_lw:  load_v = dmem_rdata;
            default: load_v = 32'h0000_0000;
        endcase
    end

    always_comb begin
        case (wb_reg.wb_sel)
            wb_alu:  rd_v = wb_reg.alu_out;
            wb_uimm: rd_v = wb_reg.u_imm;
            wb_br:   rd_v = {31'd0, wb_reg.br_en};
            wb_mem:  rd_v = load_v;
            default: rd_v = 32'h0000_0000;
        endcase
    end

    // a misaligned access retires but never writes the register file.
    assign regf_we = wb_reg.valid && (wb_reg.wb_sel != wb_none) && (wb_reg.rd_s != 5'd0)
                     && !wb_reg.misaligned;

    always_comb begin
        commit.valid      = wb_reg.valid;
        commit.order      = wb_reg.order;
        commit.pc         = wb_reg.pc;
        commit.rd_s       = wb_reg.rd_s;
        commit.rd_v       = rd_v;
        commit.regf_we    = regf_we;
        commit.misaligned = wb_reg.misaligned;
    end

endmodule

`default_nettype wire
